// ==== pu_fabric.f ====
source/pu_pkg.sv
source/div_pipe.sv
source/pu_div.sv
source/pu_mul.sv
source/pu_bus_join.sv
source/pu_fabric.sv
bench/pu_fabric_tb.sv

// ==== Makefile ====
TOP = pu_fabric_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): pu_fabric.f source/*.sv bench/*.sv
	verilator --binary --timing --assert -f pu_fabric.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -f pu_fabric.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== bench/pu_fabric_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pu_fabric_tb;

    import pu_pkg::*;

    localparam int watchdog_cycles = 20000;

    logic   clk;
    logic   rst;
    logic   wr;
    logic   wr_sel;
    logic   oe;
    logic   oe_sel;
    logic   unit;
    data_t  data_in;
    attr_t  attr_in;
    data_t  data_out;
    attr_t  attr_out;
    integer seed;

    pu_fabric DUT (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .wr_sel   (wr_sel),
        .oe       (oe),
        .oe_sel   (oe_sel),
        .unit     (unit),
        .data_in  (data_in),
        .attr_in  (attr_in),
        .data_out (data_out),
        .attr_out (attr_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    task automatic check_data(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s read %h, expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_attr(input string what, input attr_t got, input attr_t exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s read %b, expected %b", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    function automatic data_t random_word();
        return data_t'($random(seed));
    endfunction

    // nonzero divisors that fit in the lower half word.
    function automatic data_t random_divisor();
        data_t d;
        d = random_word() & 32'h0000_ffff;
        return (d == '0) ? data_t'(1) : d;
    endfunction

    function automatic attr_t flag_attr(input logic inv);
        attr_t f;
        f = '0;
        f[invalid_bit] = inv;
        return f;
    endfunction

    function automatic logic div_invalid(input attr_t aa, input data_t b, input attr_t ba);
        return aa[invalid_bit] || ba[invalid_bit] || (b == '0) || ((b >> (data_width / 2)) != '0);
    endfunction

    function automatic logic [2*data_width-1:0] mul_product(input data_t a, input data_t b);
        return {{data_width{1'b0}}, a} * {{data_width{1'b0}}, b};
    endfunction

    // inputs change a short delay after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
        end
    endtask

    task automatic idle_inputs();
        wr = 1'b0;
        wr_sel = 1'b0;
        oe = 1'b0;
        oe_sel = 1'b0;
        data_in = '0;
        attr_in = '0;
    endtask

    task automatic write_operands(input logic u, input data_t a, input attr_t aa,
                                  input data_t b, input attr_t ba);
        next_cycle();
        unit = u;
        wr = 1'b1;
        wr_sel = 1'b0;
        data_in = a;
        attr_in = aa;
        next_cycle();
        wr_sel = 1'b1;
        data_in = b;
        attr_in = ba;
        next_cycle();
        idle_inputs();
    endtask

    // low word first, then high word, each one cycle after its oe cycle.
    task automatic read_pair(input logic u, output data_t lo, output attr_t lo_attr,
                             output data_t hi, output attr_t hi_attr);
        unit = u;
        oe = 1'b1;
        oe_sel = 1'b0;
        next_cycle();
        lo = data_out;
        lo_attr = attr_out;
        oe_sel = 1'b1;
        next_cycle();
        hi = data_out;
        hi_attr = attr_out;
        oe = 1'b0;
    endtask

    task automatic run_div(input data_t a, input attr_t aa, input data_t b, input attr_t ba,
                           input logic check_words);
        data_t q;
        data_t r;
        attr_t qa;
        attr_t ra;
        write_operands(unit_div, a, aa, b, ba);
        wait_cycles(div_stages + 1);
        read_pair(unit_div, q, qa, r, ra);
        check_attr("quotient flag", qa, flag_attr(div_invalid(aa, b, ba)));
        check_attr("remainder flag", ra, flag_attr(div_invalid(aa, b, ba)));
        if (check_words) begin
            check_data("quotient", q, a / b);
            check_data("remainder", r, a % b);
        end
    endtask

    task automatic run_mul(input data_t a, input attr_t aa, input data_t b, input attr_t ba);
        data_t lo;
        data_t hi;
        attr_t lo_a;
        attr_t hi_a;
        logic [2*data_width-1:0] prod;
        logic inv;
        prod = mul_product(a, b);
        inv = aa[invalid_bit] || ba[invalid_bit] || (prod[2*data_width-1:data_width] != '0);
        write_operands(unit_mul, a, aa, b, ba);
        wait_cycles(mul_stages + 1);
        read_pair(unit_mul, lo, lo_a, hi, hi_a);
        check_data("product low word", lo, prod[data_width-1:0]);
        check_data("product high word", hi, prod[2*data_width-1:data_width]);
        check_attr("product flag", lo_a, flag_attr(inv));
        check_attr("product flag", hi_a, flag_attr(inv));
    endtask

    // starts every second cycle, with each result read in its own two-cycle window.
    task automatic run_burst(input logic u, input int n);
        data_t a_ops [4];
        data_t b_ops [4];
        data_t exp_w [8];
        attr_t exp_a [4];
        logic [2*data_width-1:0] prod;
        int lat;
        int j;
        int pend;
        lat = (u == unit_div) ? div_stages + 1 : mul_stages + 1;
        for (int i = 0; i < n; i++) begin
            a_ops[i] = random_word();
            if (u == unit_div) begin
                b_ops[i] = random_divisor();
                exp_w[2*i] = a_ops[i] / b_ops[i];
                exp_w[2*i+1] = a_ops[i] % b_ops[i];
                exp_a[i] = '0;
            end else begin
                b_ops[i] = random_word() & 32'h0000_ffff;
                prod = mul_product(a_ops[i], b_ops[i]);
                exp_w[2*i] = prod[data_width-1:0];
                exp_w[2*i+1] = prod[2*data_width-1:data_width];
                exp_a[i] = flag_attr(exp_w[2*i+1] != '0);
            end
        end
        pend = -1;
        for (int k = 0; k < 2*n + lat + 3; k++) begin
            next_cycle();
            if (pend >= 0) begin
                check_data("burst result word", data_out, exp_w[pend]);
                check_attr("burst result flag", attr_out, exp_a[pend/2]);
            end
            idle_inputs();
            unit = u;
            pend = -1;
            if (k < 2*n) begin
                wr = 1'b1;
                wr_sel = k[0];
                data_in = k[0] ? b_ops[k/2] : a_ops[k/2];
            end
            j = k - 2 - lat;
            if (j >= 0 && j < 2*n) begin
                oe = 1'b1;
                oe_sel = j[0];
                pend = j;
            end
        end
    endtask

    task automatic idle_bus_check();
        write_operands(unit_div, random_word(), '0, random_divisor(), '0);
        write_operands(unit_mul, random_word(), '0, random_word(), '0);
        for (int i = 0; i < div_stages + mul_stages + 4; i++) begin
            next_cycle();
            check_data("data_out with oe low", data_out, '0);
            check_attr("attr_out with oe low", attr_out, '0);
        end
    endtask

    initial begin
        data_t lo;
        data_t hi;
        attr_t lo_a;
        attr_t hi_a;
        seed = 50812;
        rst = 1'b1;
        unit = unit_div;
        idle_inputs();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        next_cycle();
        check_data("data_out after reset", data_out, '0);
        check_attr("attr_out after reset", attr_out, '0);
        read_pair(unit_div, lo, lo_a, hi, hi_a);
        check_data("divider before any operation", lo | hi, '0);
        check_attr("divider flag before any operation", lo_a | hi_a, '0);
        read_pair(unit_mul, lo, lo_a, hi, hi_a);
        check_data("multiplier before any operation", lo | hi, '0);
        check_attr("multiplier flag before any operation", lo_a | hi_a, '0);

        run_div(32'd5, '0, 32'd7, '0, 1'b1);
        run_div(32'd1000, 4'b1110, 32'd3, 4'b0100, 1'b1);
        for (int i = 0; i < 8; i++) begin
            run_div(random_word(), '0, random_divisor(), '0, 1'b1);
        end

        run_div(32'd100, '0, 32'd0, '0, 1'b0);
        run_div(32'd100, '0, 32'h0001_0000, '0, 1'b0);
        run_div(random_word(), flag_attr(1'b1), 32'd7, '0, 1'b0);
        run_div(32'd50, '0, 32'd5, flag_attr(1'b1), 1'b0);

        run_mul(32'd3, '0, 32'd5, '0);
        run_mul(32'd0, '0, 32'hffff_ffff, '0);
        run_mul(32'h0000_ffff, '0, 32'h0000_ffff, '0);
        run_mul(32'h0001_0000, '0, 32'h0001_0000, '0);
        run_mul(32'd12, flag_attr(1'b1), 32'd3, '0);
        run_mul(32'd4, '0, 32'd9, flag_attr(1'b1));
        run_mul(32'd6, 4'b1010, 32'd7, 4'b0110);
        for (int i = 0; i < 6; i++) begin
            run_mul(random_word(), '0, random_word() & 32'h0000_ffff, '0);
            run_mul(random_word(), '0, random_word(), '0);
        end

        run_burst(unit_div, 4);
        run_burst(unit_mul, 4);
        idle_bus_check();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/pu_fabric.sv ====
`timescale 1ns/100ps
`default_nettype none

module pu_fabric (
    input  wire            clk,
    input  wire            rst,
    input  wire            wr,
    input  wire            wr_sel,
    input  wire            oe,
    input  wire            oe_sel,
    input  wire            unit,
    input  wire pu_pkg::data_t data_in,
    input  wire pu_pkg::attr_t attr_in,
    output wire pu_pkg::data_t data_out,
    output wire pu_pkg::attr_t attr_out
);

    import pu_pkg::*;

    logic  div_wr;
    logic  div_oe;
    logic  mul_wr;
    logic  mul_oe;
    data_t div_data;
    attr_t div_attr;
    data_t mul_data;
    attr_t mul_attr;

    pu_bus_join u_bus_join (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .oe       (oe),
        .unit     (unit),
        .div_data (div_data),
        .div_attr (div_attr),
        .mul_data (mul_data),
        .mul_attr (mul_attr),
        .div_wr   (div_wr),
        .div_oe   (div_oe),
        .mul_wr   (mul_wr),
        .mul_oe   (mul_oe),
        .data_out (data_out),
        .attr_out (attr_out)
    );

    // operand and select lines reach both units and only the strobes are decoded.
    pu_div u_div (
        .clk      (clk),
        .rst      (rst),
        .wr       (div_wr),
        .wr_sel   (wr_sel),
        .data_in  (data_in),
        .attr_in  (attr_in),
        .oe       (div_oe),
        .oe_sel   (oe_sel),
        .data_out (div_data),
        .attr_out (div_attr)
    );

    pu_mul u_mul (
        .clk      (clk),
        .rst      (rst),
        .wr       (mul_wr),
        .wr_sel   (wr_sel),
        .data_in  (data_in),
        .attr_in  (attr_in),
        .oe       (mul_oe),
        .oe_sel   (oe_sel),
        .data_out (mul_data),
        .attr_out (mul_attr)
    );

endmodule

`default_nettype wire

// ==== source/pu_bus_join.sv ====
`timescale 1ns/100ps
`default_nettype none

module pu_bus_join (
    input  wire            clk,
    input  wire            rst,
    input  wire            wr,
    input  wire            oe,
    input  wire            unit,
    input  wire pu_pkg::data_t div_data,
    input  wire pu_pkg::attr_t div_attr,
    input  wire pu_pkg::data_t mul_data,
    input  wire pu_pkg::attr_t mul_attr,
    output wire            div_wr,
    output wire            div_oe,
    output wire            mul_wr,
    output wire            mul_oe,
    output pu_pkg::data_t  data_out,
    output pu_pkg::attr_t  attr_out
);

    import pu_pkg::*;

    logic sel_div;
    logic sel_mul;

    assign sel_div = (unit == unit_div);
    assign sel_mul = (unit == unit_mul);

    assign div_wr = wr && sel_div;
    assign div_oe = oe && sel_div;
    assign mul_wr = wr && sel_mul;
    assign mul_oe = oe && sel_mul;

    // an idle unit drives zero, so the merge is a plain OR.
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out <= '0;
            attr_out <= '0;
        end else begin
            data_out <= div_data | mul_data;
            attr_out <= div_attr | mul_attr;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (div_data == '0) || (mul_data == '0))
        else $error("both units drive the result bus in the same cycle");

endmodule

`default_nettype wire

// ==== source/pu_mul.sv ====
`timescale 1ns/100ps
`default_nettype none

module pu_mul (
    input  wire            clk,
    input  wire            rst,
    input  wire            wr,
    input  wire            wr_sel,
    input  wire pu_pkg::data_t data_in,
    input  wire pu_pkg::attr_t attr_in,
    input  wire            oe,
    input  wire            oe_sel,
    output wire pu_pkg::data_t data_out,
    output wire pu_pkg::attr_t attr_out
);

    import pu_pkg::*;

    localparam int half = data_width / 2;

    data_t latch_data;
    logic  latch_inv;
    data_t arg_a;
    data_t arg_b;
    logic  arg_a_inv;
    logic  arg_b_inv;
    logic  arg_new;

    logic [mul_stages-1:0] valid_sr;
    logic [mul_stages-1:0] inv_sr;

    data_t pp_ll;
    data_t pp_lh;
    data_t pp_hl;
    data_t pp_hh;
    logic [2*data_width-1:0] mid_sum;
    logic [2*data_width-1:0] prod_r;
    logic [2*data_width-1:0] result_r;
    logic                    invalid_r;
    attr_t                   flag_word;

    always_ff @(posedge clk) begin
        if (wr && !wr_sel) begin
            latch_data <= data_in;
            latch_inv  <= attr_in[invalid_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arg_a     <= '0;
            arg_b     <= '0;
            arg_a_inv <= 1'b0;
            arg_b_inv <= 1'b0;
            arg_new   <= 1'b0;
        end else begin
            arg_new <= wr && wr_sel;
            if (wr && wr_sel) begin
                arg_a     <= latch_data;
                arg_a_inv <= latch_inv;
                arg_b     <= data_in;
                arg_b_inv <= attr_in[invalid_bit];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
            inv_sr   <= '0;
        end else begin
            valid_sr <= {valid_sr[mul_stages-2:0], arg_new};
            inv_sr   <= {inv_sr[mul_stages-2:0], arg_a_inv || arg_b_inv};
        end
    end

    // the first step forms four half-word partial products.
    // the second step adds them into the full double-width product.
    assign mid_sum = {{data_width{1'b0}}, pp_lh} + {{data_width{1'b0}}, pp_hl};

    always_ff @(posedge clk) begin
        pp_ll  <= data_t'(arg_a[half-1:0]) * data_t'(arg_b[half-1:0]);
        pp_lh  <= data_t'(arg_a[half-1:0]) * data_t'(arg_b[data_width-1:half]);
        pp_hl  <= data_t'(arg_a[data_width-1:half]) * data_t'(arg_b[half-1:0]);
        pp_hh  <= data_t'(arg_a[data_width-1:half]) * data_t'(arg_b[data_width-1:half]);
        prod_r <= {pp_hh, pp_ll} + (mid_sum << half);
    end

    // a product that needs the high word does not fit the result.
    always_ff @(posedge clk) begin
        if (rst) begin
            result_r  <= '0;
            invalid_r <= 1'b0;
        end else if (valid_sr[mul_stages-1]) begin
            result_r  <= prod_r;
            invalid_r <= inv_sr[mul_stages-1] || (prod_r[2*data_width-1:data_width] != '0);
        end
    end

    always_comb begin
        flag_word = '0;
        flag_word[invalid_bit] = invalid_r;
    end

    assign data_out = oe ? (oe_sel ? result_r[2*data_width-1:data_width]
                                   : result_r[data_width-1:0]) : '0;
    assign attr_out = oe ? flag_word : '0;

endmodule

`default_nettype wire

// ==== source/pu_div.sv ====
`timescale 1ns/100ps
`default_nettype none

module pu_div (
    input  wire            clk,
    input  wire            rst,
    input  wire            wr,
    input  wire            wr_sel,
    input  wire pu_pkg::data_t data_in,
    input  wire pu_pkg::attr_t attr_in,
    input  wire            oe,
    input  wire            oe_sel,
    output wire pu_pkg::data_t data_out,
    output wire pu_pkg::attr_t attr_out
);

    import pu_pkg::*;

    data_t latch_data;
    logic  latch_inv;
    data_t arg_a;
    data_t arg_b;
    logic  arg_a_inv;
    logic  arg_b_inv;
    logic  arg_new;

    logic [div_stages-1:0] valid_sr;
    logic [div_stages-1:0] inv_sr;
    logic                  inv_pred;

    data_t core_quotient;
    data_t core_remain;
    data_t quotient_r;
    data_t remain_r;
    logic  invalid_r;
    attr_t flag_word;

    logic start;

    assign start = wr && wr_sel;

    // the first operand waits in the latch until the second one arrives.
    always_ff @(posedge clk) begin
        if (wr && !wr_sel) begin
            latch_data <= data_in;
            latch_inv  <= attr_in[invalid_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arg_a     <= '0;
            arg_b     <= '0;
            arg_a_inv <= 1'b0;
            arg_b_inv <= 1'b0;
            arg_new   <= 1'b0;
        end else begin
            arg_new <= start;
            if (start) begin
                arg_a     <= latch_data;
                arg_a_inv <= latch_inv;
                arg_b     <= data_in;
                arg_b_inv <= attr_in[invalid_bit];
            end
        end
    end

    // divisors wider than half a word are outside the supported range.
    assign inv_pred = arg_a_inv || arg_b_inv || (arg_b == '0)
                   || (arg_b[data_width-1:data_width/2] != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
            inv_sr   <= '0;
        end else begin
            valid_sr <= {valid_sr[div_stages-2:0], arg_new};
            inv_sr   <= {inv_sr[div_stages-2:0], inv_pred};
        end
    end

    div_pipe u_div_pipe (
        .clk      (clk),
        .rst      (rst),
        .numer    (arg_a),
        .denom    (arg_b),
        .quotient (core_quotient),
        .remain   (core_remain)
    );

    // results only move when a started operation leaves the core.
    always_ff @(posedge clk) begin
        if (rst) begin
            quotient_r <= '0;
            remain_r   <= '0;
            invalid_r  <= 1'b0;
        end else if (valid_sr[div_stages-1]) begin
            quotient_r <= core_quotient;
            remain_r   <= core_remain;
            invalid_r  <= inv_sr[div_stages-1];
        end
    end

    always_comb begin
        flag_word = '0;
        flag_word[invalid_bit] = invalid_r;
    end

    assign data_out = oe ? (oe_sel ? remain_r : quotient_r) : '0;
    assign attr_out = oe ? flag_word : '0;

    // each start needs a fresh latch write, so starts are never back to back.
    assert property (@(posedge clk) disable iff (rst) start |=> !start)
        else $error("pu_div started two operations in consecutive cycles");

endmodule

`default_nettype wire

// ==== source/div_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module div_pipe (
    input  wire            clk,
    input  wire            rst,
    input  wire pu_pkg::data_t numer,
    input  wire pu_pkg::data_t denom,
    output wire pu_pkg::data_t quotient,
    output wire pu_pkg::data_t remain
);

    import pu_pkg::*;

    localparam int bits_per_stage = data_width / div_stages;
    localparam int cnt_width = $clog2(div_stages + 1);

    // each stage holds the numerator bits still to shift in, the divisor,
    // the partial remainder and the quotient bits found so far.
    data_t numer_r [div_stages];
    data_t denom_r [div_stages];
    data_t rem_r [div_stages];
    data_t quo_r [div_stages];

    logic [cnt_width-1:0] settle_cnt;

    for (genvar s = 0; s < div_stages; s++) begin : g_stage
        data_t numer_i;
        data_t denom_i;
        data_t rem_i;
        data_t quo_i;
        data_t numer_n;
        data_t rem_n;
        data_t quo_n;

        if (s == 0) begin : g_first
            assign numer_i = numer;
            assign denom_i = denom;
            assign rem_i   = '0;
            assign quo_i   = '0;
        end else begin : g_next
            assign numer_i = numer_r[s-1];
            assign denom_i = denom_r[s-1];
            assign rem_i   = rem_r[s-1];
            assign quo_i   = quo_r[s-1];
        end

        // each restoring step yields one quotient bit.
        always_comb begin
            logic [data_width:0] trial;
            logic                fits;
            numer_n = numer_i;
            rem_n   = rem_i;
            quo_n   = quo_i;
            for (int b = 0; b < bits_per_stage; b++) begin
                trial   = {rem_n, numer_n[data_width-1]};
                numer_n = numer_n << 1;
                fits    = (trial >= {1'b0, denom_i});
                if (fits) begin
                    trial = trial - {1'b0, denom_i};
                end
                rem_n = trial[data_width-1:0];
                quo_n = {quo_n[data_width-2:0], fits};
            end
        end

        always_ff @(posedge clk) begin
            numer_r[s] <= numer_n;
            denom_r[s] <= denom_i;
            rem_r[s]   <= rem_n;
            quo_r[s]   <= quo_n;
        end
    end

    assign quotient = quo_r[div_stages-1];
    assign remain   = rem_r[div_stages-1];

    // counts the cycles since reset so the output check waits
    // for the pipeline to fill.
    always_ff @(posedge clk) begin
        if (rst) begin
            settle_cnt <= '0;
        end else if (settle_cnt < cnt_width'(div_stages)) begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (settle_cnt == cnt_width'(div_stages)) |-> !$isunknown({quotient, remain}))
        else $error("div_pipe output unknown after the pipeline filled");

endmodule

`default_nettype wire

// ==== source/pu_pkg.sv ====
`default_nettype none

package pu_pkg;

    // operand and result words.
    localparam int data_width = 32;
    localparam int attr_width = 4;

    // attribute bit that marks a word as invalid.
    localparam int invalid_bit = 0;

    // divider depth in registered stages.
    // It must divide data_width evenly, and each stage then resolves
    // data_width / div_stages quotient bits.
    localparam int div_stages = 4;

    // the multiplier registers its partial products and then the final sum.
    localparam int mul_stages = 2;

    // unit index values as they appear on the bus.
    localparam logic unit_div = 1'b0;
    localparam logic unit_mul = 1'b1;

    typedef logic [data_width-1:0] data_t;
    typedef logic [attr_width-1:0] attr_t;

endpackage

`default_nettype wire
